/* Bender.yml */
package:
  name: replay_engine

sources:
  - files:
      - design/replay_pkg.sv
      - design/replay_regs.sv
      - design/replay_fsm.sv
      - design/replay_addr_counter.sv
      - design/packet_buffer.sv
      - design/replay_engine_top.sv
  - target: simulation
    files:
      - sim/replay_properties.sv
      - sim/replay_checker.sv
      - sim/tb_replay_engine.sv

/* design/packet_buffer.sv */
// Single-port 64-word store with one output register; sw_rst drops any word held in it
`timescale 1ns/1ps

module packet_buffer (
  input  logic                          axi_aclk,
  input  logic                          rst_n,
  input  logic                          sw_rst,
  input  logic                          capture_en,
  input  logic                          replay_en,
  input  logic [replay_pkg::addr_w-1:0] ptr,
  input  logic [replay_pkg::data_w-1:0] s_tdata,
  input  logic                          s_tlast,
  input  logic                          s_tvalid,
  input  logic                          m_tready,
  output logic                          s_tready,
  output logic [replay_pkg::data_w-1:0] m_tdata,
  output logic                          m_tlast,
  output logic                          m_tvalid,
  output logic                          step,
  output logic                          out_empty
);

  localparam int depth = 1 << replay_pkg::addr_w;

  // Last flag sits above the data bits
  logic [replay_pkg::data_w:0] mem [0:depth-1];
  logic [replay_pkg::data_w:0] rd_word;
  logic                        wr_fire;
  logic                        load;

  assign s_tready = capture_en;
  assign wr_fire  = s_tvalid && capture_en;

  always_ff @(posedge axi_aclk) begin
    if (wr_fire) begin
      mem[ptr] <= {s_tlast, s_tdata};
    end
  end

  assign rd_word = mem[ptr];

  // Refill when empty or when the held word is taken this cycle
  assign load = replay_en && !sw_rst && (!m_tvalid || m_tready);
  assign step = wr_fire || load;

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_tvalid <= 1'b0;
    end else if (sw_rst) begin
      m_tvalid <= 1'b0;
    end else if (load) begin
      m_tvalid <= 1'b1;
    end else if (m_tready) begin
      m_tvalid <= 1'b0;
    end
  end

  // Payload only changes on a load, so it holds under back-pressure
  always_ff @(posedge axi_aclk) begin
    if (load) begin
      m_tlast <= rd_word[replay_pkg::data_w];
      m_tdata <= rd_word[replay_pkg::data_w-1:0];
    end
  end

  assign out_empty = !m_tvalid;

endmodule

/* design/replay_addr_counter.sv */
// Pointer walks mem_low to mem_high inclusive; mem_high below mem_low is not supported
`timescale 1ns/1ps

module replay_addr_counter (
  input  logic                           axi_aclk,
  input  logic                           rst_n,
  input  logic                           start_load,
  input  logic                           step,
  input  logic [replay_pkg::addr_w-1:0]  mem_low,
  input  logic [replay_pkg::addr_w-1:0]  mem_high,
  output logic [replay_pkg::addr_w-1:0]  ptr,
  output logic                           wrap,
  output logic [replay_pkg::count_w-1:0] pass_count
);

  logic at_high;

  assign at_high = (ptr == mem_high);
  // Same cycle as the step that consumes the last word of the region
  assign wrap    = step && at_high;

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (start_load) begin
      ptr <= mem_low;
    end else if (step) begin
      if (at_high) begin
        ptr <= mem_low;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // Completed passes over the region
  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      pass_count <= '0;
    end else if (start_load) begin
      pass_count <= '0;
    end else if (wrap) begin
      pass_count <= pass_count + 1'b1;
    end
  end

endmodule

/* design/replay_engine_top.sv */
// One replay queue behind plain register strobes; all logic runs on axi_aclk, no CDC
`timescale 1ns/1ps

module replay_engine_top (
  input  logic                              axi_aclk,
  input  logic                              rst_n,
  input  logic                              reg_wr,
  input  logic                              reg_rd,
  input  logic [replay_pkg::reg_addr_w-1:0] reg_addr,
  input  logic [31:0]                       reg_wdata,
  input  logic [replay_pkg::data_w-1:0]     s_tdata,
  input  logic                              s_tlast,
  input  logic                              s_tvalid,
  input  logic                              m_tready,
  output logic [31:0]                       reg_rdata,
  output logic                              s_tready,
  output logic [replay_pkg::data_w-1:0]     m_tdata,
  output logic                              m_tlast,
  output logic                              m_tvalid
);

  // Configuration and control levels
  logic                           sw_rst;
  logic                           enable;
  logic                           capture;
  logic [replay_pkg::addr_w-1:0]  mem_low;
  logic [replay_pkg::addr_w-1:0]  mem_high;
  logic [replay_pkg::count_w-1:0] replay_count;

  // Status back to the register bank
  logic                           busy;
  logic                           done;
  logic [replay_pkg::count_w-1:0] pass_count;

  // Sequencing between FSM, counter and buffer
  logic                           start_load;
  logic                           capture_en;
  logic                           replay_en;
  logic                           wrap;
  logic                           step;
  logic                           out_empty;
  logic [replay_pkg::addr_w-1:0]  ptr;

  replay_regs u_regs (
    .axi_aclk     (axi_aclk),
    .rst_n        (rst_n),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .busy         (busy),
    .done         (done),
    .pass_count   (pass_count),
    .reg_rdata    (reg_rdata),
    .sw_rst       (sw_rst),
    .enable       (enable),
    .capture      (capture),
    .mem_low      (mem_low),
    .mem_high     (mem_high),
    .replay_count (replay_count)
  );

  replay_fsm u_fsm (
    .axi_aclk     (axi_aclk),
    .rst_n        (rst_n),
    .sw_rst       (sw_rst),
    .enable       (enable),
    .capture      (capture),
    .wrap         (wrap),
    .pass_count   (pass_count),
    .replay_count (replay_count),
    .out_empty    (out_empty),
    .start_load   (start_load),
    .capture_en   (capture_en),
    .replay_en    (replay_en),
    .busy         (busy),
    .done         (done)
  );

  replay_addr_counter u_counter (
    .axi_aclk   (axi_aclk),
    .rst_n      (rst_n),
    .start_load (start_load),
    .step       (step),
    .mem_low    (mem_low),
    .mem_high   (mem_high),
    .ptr        (ptr),
    .wrap       (wrap),
    .pass_count (pass_count)
  );

  packet_buffer u_buffer (
    .axi_aclk   (axi_aclk),
    .rst_n      (rst_n),
    .sw_rst     (sw_rst),
    .capture_en (capture_en),
    .replay_en  (replay_en),
    .ptr        (ptr),
    .s_tdata    (s_tdata),
    .s_tlast    (s_tlast),
    .s_tvalid   (s_tvalid),
    .m_tready   (m_tready),
    .s_tready   (s_tready),
    .m_tdata    (m_tdata),
    .m_tlast    (m_tlast),
    .m_tvalid   (m_tvalid),
    .step       (step),
    .out_empty  (out_empty)
  );

endmodule

/* design/replay_fsm.sv */
// Capture beats replay from idle; a replay count of zero runs until enable is cleared
`timescale 1ns/1ps

module replay_fsm (
  input  logic                           axi_aclk,
  input  logic                           rst_n,
  input  logic                           sw_rst,
  input  logic                           enable,
  input  logic                           capture,
  input  logic                           wrap,
  input  logic [replay_pkg::count_w-1:0] pass_count,
  input  logic [replay_pkg::count_w-1:0] replay_count,
  input  logic                           out_empty,
  output logic                           start_load,
  output logic                           capture_en,
  output logic                           replay_en,
  output logic                           busy,
  output logic                           done
);

  replay_pkg::replay_state_e state_q;
  replay_pkg::replay_state_e state_d;
  logic                      endless;
  logic                      last_issued;

  assign endless     = (replay_count == '0);
  // Every requested pass has been loaded into the output stage
  assign last_issued = !endless && (pass_count == replay_count);

  always_comb begin
    state_d    = state_q;
    start_load = 1'b0;
    case (state_q)
      replay_pkg::ST_IDLE: begin
        if (capture) begin
          state_d    = replay_pkg::ST_CAPTURE;
          start_load = 1'b1;
        end else if (enable) begin
          state_d    = replay_pkg::ST_REPLAY;
          start_load = 1'b1;
        end
      end
      // Buffer region is full after the first wrap
      replay_pkg::ST_CAPTURE: begin
        if (wrap || !capture) begin
          state_d = replay_pkg::ST_DONE;
        end
      end
      replay_pkg::ST_REPLAY: begin
        if ((last_issued || !enable) && out_empty) begin
          state_d = replay_pkg::ST_DONE;
        end
      end
      replay_pkg::ST_DONE: begin
        if (!capture && !enable) begin
          state_d = replay_pkg::ST_IDLE;
        end
      end
      default: state_d = replay_pkg::ST_IDLE;
    endcase
    if (sw_rst) begin
      state_d    = replay_pkg::ST_IDLE;
      start_load = 1'b0;
    end
  end

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= replay_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign capture_en = (state_q == replay_pkg::ST_CAPTURE);
  // Stop fetching once the last pass is out or software drops enable
  assign replay_en  = (state_q == replay_pkg::ST_REPLAY) && enable && !last_issued;
  assign busy       = capture_en || (state_q == replay_pkg::ST_REPLAY);
  assign done       = (state_q == replay_pkg::ST_DONE);

endmodule

/* design/replay_pkg.sv */
// Sizes, register map and FSM states for a single-queue engine with a 64-word on-chip buffer
package replay_pkg;

  // Stream and buffer sizing
  localparam int data_w     = 32;
  localparam int addr_w     = 6;
  localparam int count_w    = 16;
  localparam int reg_addr_w = 3;

  // Register map, word addressed
  typedef enum logic [reg_addr_w-1:0] {
    REG_CTRL         = 3'd0,
    REG_MEM_LOW      = 3'd1,
    REG_MEM_HIGH     = 3'd2,
    REG_REPLAY_COUNT = 3'd3,
    REG_STATUS       = 3'd4
  } reg_addr_e;

  // Control register bit positions
  localparam int ctrl_sw_rst_bit  = 0;
  localparam int ctrl_enable_bit  = 1;
  localparam int ctrl_capture_bit = 2;

  // Engine states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_CAPTURE = 2'd1,
    ST_REPLAY  = 2'd2,
    ST_DONE    = 2'd3
  } replay_state_e;

  // Register values after reset
  localparam logic [addr_w-1:0]  def_mem_low      = '0;
  localparam logic [addr_w-1:0]  def_mem_high     = 6'd7;
  localparam logic [count_w-1:0] def_replay_count = 16'd1;

endpackage

/* design/replay_regs.sv */
// Plain strobe register bank; writes land on the strobe edge, read data appears one cycle later
`timescale 1ns/1ps

module replay_regs (
  input  logic                              axi_aclk,
  input  logic                              rst_n,
  input  logic                              reg_wr,
  input  logic                              reg_rd,
  input  logic [replay_pkg::reg_addr_w-1:0] reg_addr,
  input  logic [31:0]                       reg_wdata,
  input  logic                              busy,
  input  logic                              done,
  input  logic [replay_pkg::count_w-1:0]    pass_count,
  output logic [31:0]                       reg_rdata,
  output logic                              sw_rst,
  output logic                              enable,
  output logic                              capture,
  output logic [replay_pkg::addr_w-1:0]     mem_low,
  output logic [replay_pkg::addr_w-1:0]     mem_high,
  output logic [replay_pkg::count_w-1:0]    replay_count
);

  replay_pkg::reg_addr_e reg_sel;
  logic [31:0]           status_word;
  logic [31:0]           rd_mux;

  assign reg_sel = replay_pkg::reg_addr_e'(reg_addr);

  // Passes completed in the upper half, flags in the low bits
  assign status_word = {pass_count, 14'd0, done, busy};

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      sw_rst       <= 1'b0;
      enable       <= 1'b0;
      capture      <= 1'b0;
      mem_low      <= replay_pkg::def_mem_low;
      mem_high     <= replay_pkg::def_mem_high;
      replay_count <= replay_pkg::def_replay_count;
    end else if (reg_wr) begin
      case (reg_sel)
        replay_pkg::REG_CTRL: begin
          sw_rst  <= reg_wdata[replay_pkg::ctrl_sw_rst_bit];
          enable  <= reg_wdata[replay_pkg::ctrl_enable_bit];
          capture <= reg_wdata[replay_pkg::ctrl_capture_bit];
        end
        replay_pkg::REG_MEM_LOW:      mem_low      <= reg_wdata[replay_pkg::addr_w-1:0];
        replay_pkg::REG_MEM_HIGH:     mem_high     <= reg_wdata[replay_pkg::addr_w-1:0];
        replay_pkg::REG_REPLAY_COUNT: replay_count <= reg_wdata[replay_pkg::count_w-1:0];
        // Status is read only
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_mux = '0;
    case (reg_sel)
      replay_pkg::REG_CTRL: begin
        rd_mux[replay_pkg::ctrl_sw_rst_bit]  = sw_rst;
        rd_mux[replay_pkg::ctrl_enable_bit]  = enable;
        rd_mux[replay_pkg::ctrl_capture_bit] = capture;
      end
      replay_pkg::REG_MEM_LOW:      rd_mux[replay_pkg::addr_w-1:0]  = mem_low;
      replay_pkg::REG_MEM_HIGH:     rd_mux[replay_pkg::addr_w-1:0]  = mem_high;
      replay_pkg::REG_REPLAY_COUNT: rd_mux[replay_pkg::count_w-1:0] = replay_count;
      replay_pkg::REG_STATUS:       rd_mux = status_word;
      default:                      rd_mux = '0;
    endcase
  end

  // Read data holds until the next read strobe
  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

/* files.f */
design/replay_pkg.sv
design/replay_regs.sv
design/replay_fsm.sv
design/replay_addr_counter.sv
design/packet_buffer.sv
design/replay_engine_top.sv
sim/replay_properties.sv
sim/replay_checker.sv
sim/tb_replay_engine.sv

/* sim/replay_checker.sv */
// Reads E and R lines of sim/replay_golden.txt at time zero; compares in order of arrival
`timescale 1ns/1ps

module replay_checker (
  input  logic                          axi_aclk,
  input  logic                          rst_n,
  input  logic                          reg_rd,
  input  logic                          rd_expect,
  input  logic [31:0]                   reg_rdata,
  input  logic [replay_pkg::data_w-1:0] m_tdata,
  input  logic                          m_tlast,
  input  logic                          m_tvalid,
  input  logic                          m_tready,
  output int                            error_count,
  output int                            pending_words
);

  // Last flag above the data bits
  logic [replay_pkg::data_w:0] exp_out [$];
  logic [31:0]                 exp_rd [$];
  logic [replay_pkg::data_w:0] exp_word;
  logic [31:0]                 exp_value;
  logic [31:0]                 words [0:15];
  logic [31:0]                 reps;
  logic [31:0]                 n;
  logic [31:0]                 mask;
  logic [31:0]                 addr;
  logic [8*128-1:0]            line;
  logic [7:0]                  cmd;
  logic                        rd_pending;
  int                          fd;
  int                          code;

  initial begin
    error_count = 0;
    fd = $fopen("sim/replay_golden.txt", "r");
    if (fd == 0) begin
      $display("Golden file sim/replay_golden.txt could not be opened by the checker");
      error_count++;
    end else begin
      while ($fscanf(fd, " %c", cmd) == 1) begin
        if (cmd == "E") begin
          code = $fscanf(fd, "%h %h %h", reps, n, mask);
          for (int i = 0; i < n; i++) begin
            code = $fscanf(fd, "%h", words[i]);
          end
          for (int r = 0; r < reps; r++) begin
            for (int i = 0; i < n; i++) begin
              exp_out.push_back({mask[i], words[i]});
            end
          end
        end else if (cmd == "R") begin
          code = $fscanf(fd, "%h %h", addr, exp_value);
          exp_rd.push_back(exp_value);
        end else begin
          code = $fgets(line, fd);
        end
      end
      $fclose(fd);
    end
    pending_words = exp_out.size();
  end

  always @(posedge axi_aclk) begin
    if (!rst_n) begin
      rd_pending <= 1'b0;
    end else begin
      // Data of a checked read landed on the previous edge
      if (rd_pending) begin
        if (exp_rd.size() == 0) begin
          $display("Register read at %0t has no expected value left", $time);
          error_count++;
        end else begin
          exp_value = exp_rd.pop_front();
          if (reg_rdata !== exp_value) begin
            $display("[ERROR] %0t reg_rdata expected %h got %h", $time, exp_value, reg_rdata);
            error_count++;
          end
        end
      end
      rd_pending <= reg_rd && rd_expect;
      if (m_tvalid && m_tready) begin
        if (exp_out.size() == 0) begin
          $display("Extra output word %h at %0t, no word was expected", m_tdata, $time);
          error_count++;
        end else begin
          exp_word = exp_out.pop_front();
          pending_words = exp_out.size();
          if (m_tdata !== exp_word[replay_pkg::data_w-1:0]) begin
            $display("[ERROR] %0t m_tdata expected %h got %h",
                     $time, exp_word[replay_pkg::data_w-1:0], m_tdata);
            error_count++;
          end
          if (m_tlast !== exp_word[replay_pkg::data_w]) begin
            $display("[ERROR] %0t m_tlast expected %b got %b",
                     $time, exp_word[replay_pkg::data_w], m_tlast);
            error_count++;
          end
        end
      end
    end
  end

  task automatic check_leftovers();
    if (exp_out.size() != 0) begin
      $display("%0d expected output words never appeared on the stream", exp_out.size());
      error_count++;
    end
    if (exp_rd.size() != 0) begin
      $display("%0d expected register reads were never issued", exp_rd.size());
      error_count++;
    end
  endtask

endmodule

/* sim/replay_golden.txt */
# W addr data | R addr expected | S/E reps count lastmask words (hex, mask bit i = word i)
# P polls status until done | H stalls m_tready once every expected word is out
R 2 00000007
R 3 00000001
R 4 00000000
W 0 4
S 1 8 a4 c0de0000 c0de0011 c0de0022 c0de0033 c0de0044 c0de0055 c0de0066 c0de0077
P
W 0 0
W 0 2
E 1 8 a4 c0de0000 c0de0011 c0de0022 c0de0033 c0de0044 c0de0055 c0de0066 c0de0077
P
R 4 00010002
W 0 0
W 1 2
W 2 5
W 3 3
W 0 2
E 3 4 9 c0de0022 c0de0033 c0de0044 c0de0055
P
R 4 00030002
W 0 0
W 1 4
W 2 7
W 3 0
W 0 2
E 2 4 a c0de0044 c0de0055 c0de0066 c0de0077
H
W 0 0
W 0 1
W 0 0
R 4 00020000

/* sim/replay_properties.sv */
// Bound into replay_engine_top; sw_rst may drop m_tvalid under back-pressure
`timescale 1ns/1ps

module replay_properties (
  input logic                          axi_aclk,
  input logic                          rst_n,
  input logic                          sw_rst,
  input logic                          s_tready,
  input logic [replay_pkg::data_w-1:0] m_tdata,
  input logic                          m_tlast,
  input logic                          m_tvalid,
  input logic                          m_tready
);

  int fail_count = 0;

  // Held word stays put while the sink stalls
  a_hold_stable: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    m_tvalid && !m_tready && !sw_rst |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
  else begin
    $error("m_tdata or m_tlast changed, or m_tvalid fell, under back-pressure");
    fail_count++;
  end

  // Capture and replay never overlap
  a_one_direction: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    !(s_tready && m_tvalid))
  else begin
    $error("s_tready and m_tvalid high together");
    fail_count++;
  end

  a_reset_quiet: assert property (@(posedge axi_aclk) !rst_n |=> !s_tready && !m_tvalid)
  else begin
    $error("s_tready or m_tvalid active after reset");
    fail_count++;
  end

endmodule

bind replay_engine_top replay_properties u_props (
  .axi_aclk (axi_aclk),
  .rst_n    (rst_n),
  .sw_rst   (sw_rst),
  .s_tready (s_tready),
  .m_tdata  (m_tdata),
  .m_tlast  (m_tlast),
  .m_tvalid (m_tvalid),
  .m_tready (m_tready)
);

/* sim/tb_replay_engine.sv */
// Run from the project root so sim/replay_golden.txt resolves; m_tready is random, high ~70%
`timescale 1ns/1ps

module tb_replay_engine;

  logic                              axi_aclk;
  logic                              rst_n;
  logic                              reg_wr;
  logic                              reg_rd;
  logic [replay_pkg::reg_addr_w-1:0] reg_addr;
  logic [31:0]                       reg_wdata;
  logic [31:0]                       reg_rdata;
  logic [replay_pkg::data_w-1:0]     s_tdata;
  logic                              s_tlast;
  logic                              s_tvalid;
  logic                              s_tready;
  logic [replay_pkg::data_w-1:0]     m_tdata;
  logic                              m_tlast;
  logic                              m_tvalid;
  logic                              m_tready;

  logic                              rd_expect;
  logic                              halt_ready;
  logic [31:0]                       seed;
  logic [8*128-1:0]                  line;
  int                                error_count;
  int                                pending_words;
  int                                golden_lines;
  int                                tb_errors;
  int                                total_errors;
  int                                fd;

  replay_engine_top u_dut (
    .axi_aclk  (axi_aclk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .s_tdata   (s_tdata),
    .s_tlast   (s_tlast),
    .s_tvalid  (s_tvalid),
    .m_tready  (m_tready),
    .reg_rdata (reg_rdata),
    .s_tready  (s_tready),
    .m_tdata   (m_tdata),
    .m_tlast   (m_tlast),
    .m_tvalid  (m_tvalid)
  );

  replay_checker u_chk (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .reg_rd        (reg_rd),
    .rd_expect     (rd_expect),
    .reg_rdata     (reg_rdata),
    .m_tdata       (m_tdata),
    .m_tlast       (m_tlast),
    .m_tvalid      (m_tvalid),
    .m_tready      (m_tready),
    .error_count   (error_count),
    .pending_words (pending_words)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #5 axi_aclk = ~axi_aclk;
  end

  // Sink stalls for good once the last expected word has gone out after an H line
  initial begin
    seed = $urandom(29783);
    forever begin
      @(negedge axi_aclk);
      if (halt_ready && pending_words == 0) begin
        m_tready = 1'b0;
      end else begin
        m_tready = (($urandom % 100) < 70);
      end
    end
  end

  initial begin
    wait (golden_lines > 0);
    repeat (golden_lines * 200) @(posedge axi_aclk);
    $display("Timeout: the run did not finish within %0d cycles", golden_lines * 200);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge axi_aclk);
    reg_wr    = 1'b0;
  endtask

  // Read data is valid at the falling edge after the strobe
  task automatic read_reg(input logic [2:0] addr, input logic checked);
    reg_rd    = 1'b1;
    rd_expect = checked;
    reg_addr  = addr;
    @(negedge axi_aclk);
    reg_rd    = 1'b0;
    rd_expect = 1'b0;
  endtask

  task automatic wait_done();
    do begin
      read_reg(replay_pkg::REG_STATUS, 1'b0);
    end while (!reg_rdata[1]);
  endtask

  task automatic send_word(input logic [31:0] data, input logic last);
    s_tdata  = data;
    s_tlast  = last;
    s_tvalid = 1'b1;
    @(posedge axi_aclk);
    while (!s_tready) begin
      @(posedge axi_aclk);
    end
    @(negedge axi_aclk);
    s_tvalid = 1'b0;
  endtask

  task automatic run_golden();
    int          gfd;
    int          code;
    logic [7:0]  cmd;
    logic [31:0] reps;
    logic [31:0] n;
    logic [31:0] mask;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] words [0:15];
    gfd = $fopen("sim/replay_golden.txt", "r");
    while ($fscanf(gfd, " %c", cmd) == 1) begin
      case (cmd)
        "W": begin
          code = $fscanf(gfd, "%h %h", addr, data);
          write_reg(addr[2:0], data);
        end
        "R": begin
          code = $fscanf(gfd, "%h %h", addr, data);
          read_reg(addr[2:0], 1'b1);
        end
        "S": begin
          code = $fscanf(gfd, "%h %h %h", reps, n, mask);
          for (int i = 0; i < n; i++) begin
            code = $fscanf(gfd, "%h", words[i]);
          end
          for (int r = 0; r < reps; r++) begin
            for (int i = 0; i < n; i++) begin
              send_word(words[i], mask[i]);
            end
          end
        end
        "P": wait_done();
        "H": begin
          halt_ready = 1'b1;
          while (pending_words != 0) begin
            @(negedge axi_aclk);
          end
          @(negedge axi_aclk);
        end
        // Skip E lines and comment lines
        default: code = $fgets(line, gfd);
      endcase
    end
    $fclose(gfd);
  endtask

  initial begin
    rst_n        = 1'b0;
    reg_wr       = 1'b0;
    reg_rd       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    s_tdata      = '0;
    s_tlast      = 1'b0;
    s_tvalid     = 1'b0;
    m_tready     = 1'b0;
    rd_expect    = 1'b0;
    halt_ready   = 1'b0;
    tb_errors    = 0;
    golden_lines = 0;
    fd = $fopen("sim/replay_golden.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) begin
          golden_lines++;
        end
      end
      $fclose(fd);
    end
    repeat (10) @(posedge axi_aclk);
    @(negedge axi_aclk);
    rst_n = 1'b1;
    @(negedge axi_aclk);
    if (golden_lines == 0) begin
      $display("Golden file is missing or empty, no stimulus was applied");
      tb_errors++;
    end else begin
      run_golden();
    end
    repeat (5) @(negedge axi_aclk);
    u_chk.check_leftovers();
    total_errors = error_count + u_dut.u_props.fail_count + tb_errors;
    $display("Errors: %0d checker, %0d assertion, %0d testbench, %0d total",
             error_count, u_dut.u_props.fail_count, tb_errors, total_errors);
    if (total_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
